// File: rtl/lcd_pattern_pkg.sv
`default_nettype none

package lcd_pattern_pkg;

    // frame geometry widths
    localparam int COORD_W = 10;
    localparam int ADDR_W  = 20;

    // 8:8:8 pixel word
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // ------------------------------------------------------------------------
    // palette
    // ------------------------------------------------------------------------
    localparam rgb_t RED     = 24'hFF0000;
    localparam rgb_t GREEN   = 24'h00FF00;
    localparam rgb_t BLUE    = 24'h0000FF;
    localparam rgb_t WHITE   = 24'hFFFFFF;
    localparam rgb_t BLACK   = 24'h000000;
    localparam rgb_t YELLOW  = 24'hFFFF00;
    localparam rgb_t MAGENTA = 24'hFF00FF;
    localparam rgb_t CYAN    = 24'h00FFFF;

    // background pattern opcodes
    typedef enum logic [1:0] {
        PAT_SOLID,
        PAT_HBARS,
        PAT_RAMP
    } pattern_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_LOAD,
        ST_FILL,
        ST_DONE
    } fill_state_t;

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        pattern_op_t        bg_op;
        rgb_t               bg_color;
        rgb_t               fg_color;
        logic [COORD_W-1:0] win_top;
        logic [COORD_W-1:0] win_bottom;
    } pattern_cfg_t;

    // what one phase paints
    typedef struct packed {
        pattern_op_t op;
        rgb_t        color;
    } fill_cmd_t;

    // inclusive row span of one phase
    typedef struct packed {
        logic [COORD_W-1:0] row_first;
        logic [COORD_W-1:0] row_last;
    } row_range_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        rgb_t              data;
    } fb_wr_t;

endpackage

`default_nettype wire

// File: rtl/write_pacer.sv
`timescale 1ns/1ps
`default_nettype none

module write_pacer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] divide,
    output logic       tick
);

    // position inside the current pace period
    logic [7:0] cnt;
    // period limit, taken from divide at each wrap
    logic [7:0] limit;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt   <= 8'd0;
            limit <= 8'd0;
        end
        else if (cnt == limit)
        begin
            // wrap, new divide applies from here
            cnt   <= 8'd0;
            limit <= divide;
        end
        else
        begin
            cnt <= cnt + 8'd1;
        end
    end

    // one pixel slot per divide+1 clocks
    assign tick = (cnt == 8'd0);

endmodule

`default_nettype wire

// File: rtl/fill_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fill_sequencer #(
    parameter int V_DISP = 12
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         mem_ready,
    input  lcd_pattern_pkg::pattern_cfg_t cfg,
    input  logic                         last,
    output logic                         load,
    output lcd_pattern_pkg::row_range_t  range,
    output lcd_pattern_pkg::fill_cmd_t   cmd,
    output logic                         active,
    output logic                         busy,
    output logic                         done
);

    import lcd_pattern_pkg::*;

    // bottom row of the frame
    localparam logic [COORD_W-1:0] ROW_END = COORD_W'(V_DISP - 1);

    fill_state_t  state;
    fill_state_t  state_nxt;
    pattern_cfg_t cfg_q;
    // low for background, high for window
    logic         win_phase;
    logic         win_ok;
    logic         accept;

    assign accept = (state == ST_IDLE) && start;

    // window rows must be ordered and inside the frame
    assign win_ok = (cfg_q.win_top <= cfg_q.win_bottom) && (cfg_q.win_bottom <= ROW_END);

    // ------------------------------------------------------------------------
    // state register and phase flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            win_phase <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
                win_phase <= 1'b0;
            else if (state == ST_FILL && last && !win_phase && win_ok)
                win_phase <= 1'b1;
        end
    end

    // config held for the whole run
    always_ff @(posedge clk)
    begin
        if (accept)
            cfg_q <= cfg;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (start)
                    state_nxt = ST_WAIT_READY;
            ST_WAIT_READY:
                if (mem_ready)
                    state_nxt = ST_LOAD;
            ST_LOAD:
                state_nxt = ST_FILL;
            ST_FILL:
                if (last)
                    state_nxt = (!win_phase && win_ok) ? ST_WAIT_READY : ST_DONE;
            ST_DONE:
                state_nxt = ST_IDLE;
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // phase command and row span
    // ------------------------------------------------------------------------
    always_comb
    begin
        if (win_phase)
        begin
            range.row_first = cfg_q.win_top;
            range.row_last  = cfg_q.win_bottom;
            cmd.op          = PAT_SOLID;
            cmd.color       = cfg_q.fg_color;
        end
        else
        begin
            range.row_first = '0;
            range.row_last  = ROW_END;
            cmd.op          = cfg_q.bg_op;
            cmd.color       = cfg_q.bg_color;
        end
    end

    assign load   = (state == ST_LOAD);
    // stop stepping in the cycle the final write shows up
    assign active = (state == ST_FILL) && !last;
    assign busy   = (state != ST_IDLE) && (state != ST_DONE);
    assign done   = (state == ST_DONE);

endmodule

`default_nettype wire

// File: rtl/fb_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fb_addr_gen #(
    parameter int H_DISP = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load,
    input  lcd_pattern_pkg::row_range_t         range,
    input  logic                                tick,
    input  logic                                active,
    output logic [lcd_pattern_pkg::COORD_W-1:0] x,
    output logic [lcd_pattern_pkg::COORD_W-1:0] y,
    output logic                                wr_en,
    output logic [lcd_pattern_pkg::ADDR_W-1:0]  addr,
    output logic                                last
);

    import lcd_pattern_pkg::*;

    // rightmost column
    localparam logic [COORD_W-1:0] X_LAST = COORD_W'(H_DISP - 1);

    logic [ADDR_W-1:0]  addr_cnt;
    logic [COORD_W-1:0] row_last_q;
    logic               step;

    assign step = tick && active;

    // ------------------------------------------------------------------------
    // raster position and linear address
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x          <= '0;
            y          <= '0;
            addr_cnt   <= '0;
            row_last_q <= '0;
        end
        else if (load)
        begin
            x          <= '0;
            y          <= range.row_first;
            addr_cnt   <= ADDR_W'(range.row_first) * ADDR_W'(H_DISP);
            row_last_q <= range.row_last;
        end
        else if (step)
        begin
            addr_cnt <= addr_cnt + ADDR_W'(1);
            // end of line wraps into next row
            if (x == X_LAST)
            begin
                x <= '0;
                y <= y + COORD_W'(1);
            end
            else
            begin
                x <= x + COORD_W'(1);
            end
        end
    end

    // write strobe and end marker one cycle after the tick
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_en <= 1'b0;
            last  <= 1'b0;
        end
        else
        begin
            wr_en <= step;
            last  <= step && (x == X_LAST) && (y == row_last_q);
        end
    end

    always_ff @(posedge clk)
    begin
        if (step)
            addr <= addr_cnt;
    end

endmodule

`default_nettype wire

// File: rtl/pixel_source.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_source #(
    parameter int H_DISP = 16,
    parameter int V_DISP = 12
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tick,
    input  logic                                active,
    input  lcd_pattern_pkg::fill_cmd_t          cmd,
    input  logic [lcd_pattern_pkg::COORD_W-1:0] x,
    input  logic [lcd_pattern_pkg::COORD_W-1:0] y,
    output lcd_pattern_pkg::rgb_t               data
);

    import lcd_pattern_pkg::*;

    rgb_t       color;
    rgb_t       bar;
    logic [7:0] ramp;
    logic       in_frame;

    // positions past the frame edge paint black
    assign in_frame = (x < COORD_W'(H_DISP)) && (y < COORD_W'(V_DISP));

    // gray level of x times 16
    assign ramp = {x[3:0], 4'h0};

    // eight bands repeating every eight rows
    always_comb
    begin
        case (y[2:0])
            3'd0:    bar = RED;
            3'd1:    bar = GREEN;
            3'd2:    bar = BLUE;
            3'd3:    bar = WHITE;
            3'd4:    bar = BLACK;
            3'd5:    bar = YELLOW;
            3'd6:    bar = MAGENTA;
            default: bar = CYAN;
        endcase
    end

    always_comb
    begin
        color = BLACK;
        if (in_frame)
        begin
            case (cmd.op)
                PAT_SOLID: color = cmd.color;
                PAT_HBARS: color = bar;
                PAT_RAMP:  color = '{r: ramp, g: ramp, b: ramp};
                default:   color = BLACK;
            endcase
        end
    end

    // same tick as the address register so data lines up with wr_en
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            data <= BLACK;
        else if (tick && active)
            data <= color;
    end

endmodule

`default_nettype wire

// File: rtl/lcd_pattern_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_pattern_top #(
    parameter int H_DISP = 16,
    parameter int V_DISP = 12
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          mem_ready,
    input  lcd_pattern_pkg::pattern_cfg_t cfg,
    input  logic [7:0]                    divide,
    output logic                          wr_en,
    output lcd_pattern_pkg::fb_wr_t       wr,
    output logic                          busy,
    output logic                          done
);

    import lcd_pattern_pkg::*;

    // ------------------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------------------
    logic               tick;
    logic               load;
    logic               active;
    logic               last;
    row_range_t         range;
    fill_cmd_t          cmd;
    logic [COORD_W-1:0] pos_x;
    logic [COORD_W-1:0] pos_y;
    logic [ADDR_W-1:0]  fb_addr;
    rgb_t               fb_data;

    // pixel pace
    write_pacer u_pacer (
        .clk    (clk),
        .rst_n  (rst_n),
        .divide (divide),
        .tick   (tick)
    );

    fill_sequencer #(
        .V_DISP (V_DISP)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .mem_ready (mem_ready),
        .cfg       (cfg),
        .last      (last),
        .load      (load),
        .range     (range),
        .cmd       (cmd),
        .active    (active),
        .busy      (busy),
        .done      (done)
    );

    fb_addr_gen #(
        .H_DISP (H_DISP)
    ) u_addr (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .range  (range),
        .tick   (tick),
        .active (active),
        .x      (pos_x),
        .y      (pos_y),
        .wr_en  (wr_en),
        .addr   (fb_addr),
        .last   (last)
    );

    pixel_source #(
        .H_DISP (H_DISP),
        .V_DISP (V_DISP)
    ) u_pix (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .active (active),
        .cmd    (cmd),
        .x      (pos_x),
        .y      (pos_y),
        .data   (fb_data)
    );

    // write bundle to the frame buffer
    assign wr.addr = fb_addr;
    assign wr.data = fb_data;

endmodule

`default_nettype wire

// File: testbench/lcd_pattern_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_pattern_assert #(
    parameter int H_DISP = 16,
    parameter int V_DISP = 12
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    wr_en,
    input lcd_pattern_pkg::fb_wr_t wr,
    input logic                    busy,
    input logic                    done
);

    import lcd_pattern_pkg::*;

    // pixels in one frame
    localparam logic [ADDR_W-1:0] N_PIX = ADDR_W'(H_DISP * V_DISP);

    // writes only inside a run
    a_wr_in_run: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> busy)
        else $error("wr_en high while busy is low");

    // address stays inside the frame
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr.addr < N_PIX))
        else $error("write address beyond the frame");

    // single-cycle done, run already over
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> (!done && !busy))
        else $error("done longer than one cycle or busy still high");

    // quiet outputs right after reset release
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> (!wr_en && !done))
        else $error("wr_en or done high after reset release");

endmodule

bind lcd_pattern_top lcd_pattern_assert #(
    .H_DISP (H_DISP),
    .V_DISP (V_DISP)
) u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (wr_en),
    .wr    (wr),
    .busy  (busy),
    .done  (done)
);

`default_nettype wire

// File: testbench/lcd_pattern_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_pattern_tb;

    import lcd_pattern_pkg::*;

    localparam int H_DISP = 16;
    localparam int V_DISP = 12;
    localparam int NPIX   = H_DISP * V_DISP;
    localparam int N_ROWS = 6;
    localparam int SEED   = 24099;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         mem_ready;
    pattern_cfg_t cfg;
    logic [7:0]   divide;
    logic         wr_en;
    fb_wr_t       wr;
    logic         busy;
    logic         done;

    // frame-buffer model and per-address write counts
    rgb_t   fb_mem [NPIX];
    int     wr_cnt [NPIX];
    // write log of the current run
    logic [ADDR_W-1:0] log_addr [$];
    longint            log_cycle [$];
    longint            cycle;
    longint            done_cycle;
    int                done_cnt;
    int                errors;
    int                checks;

    // stimulus table of config, divide and mem_ready delay
    pattern_cfg_t tab_cfg [N_ROWS];
    logic [7:0]   tab_div [N_ROWS];
    int           tab_delay [N_ROWS];
    int           tab_len;
    rgb_t         palette [8];

    lcd_pattern_top #(
        .H_DISP (H_DISP),
        .V_DISP (V_DISP)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .mem_ready (mem_ready),
        .cfg       (cfg),
        .divide    (divide),
        .wr_en     (wr_en),
        .wr        (wr),
        .busy      (busy),
        .done      (done)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        checks = checks + 1;
        if (exp !== act)
        begin
            errors = errors + 1;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        checks = checks + 1;
        if (exp !== act)
        begin
            errors = errors + 1;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks = checks + 1;
        if (exp != act)
        begin
            errors = errors + 1;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        errors = errors + 1;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic bit window_valid(input pattern_cfg_t c);
        return (c.win_top <= c.win_bottom) && (int'(c.win_bottom) < V_DISP);
    endfunction

    function automatic rgb_t background_pixel(input pattern_cfg_t c, input int px, input int py);
        rgb_t       p;
        logic [7:0] gray;
        p = c.bg_color;
        case (c.bg_op)
            PAT_HBARS:
                p = palette[py % 8];
            PAT_RAMP:
            begin
                // low byte of x*16
                gray = 8'((px * 16) % 256);
                p.r  = gray;
                p.g  = gray;
                p.b  = gray;
            end
            default:
                p = c.bg_color;
        endcase
        return p;
    endfunction

    task automatic add_row(input pattern_op_t op, input rgb_t bg, input rgb_t fg,
                           input int top, input int bottom, input int div, input int delay);
        pattern_cfg_t c;
        c.bg_op                = op;
        c.bg_color             = bg;
        c.fg_color             = fg;
        c.win_top              = COORD_W'(top);
        c.win_bottom           = COORD_W'(bottom);
        tab_cfg[tab_len]       = c;
        tab_div[tab_len]       = 8'(div);
        tab_delay[tab_len]     = delay;
        tab_len                = tab_len + 1;
    endtask

    task automatic build_table();
        // valid window at the fastest pace
        add_row(PAT_SOLID, BLUE, YELLOW, 3, 5, 0, 4);
        // empty window with top above bottom
        add_row(PAT_HBARS, BLACK, WHITE, 7, 2, 1, 10);
        // window down to the last row
        add_row(PAT_RAMP, BLACK, RED, 8, 11, 5, 0);
        add_row(PAT_HBARS, BLACK, CYAN, 0, 0, 0, 2);
        // bottom past the frame so the window is skipped
        add_row(PAT_RAMP, WHITE, MAGENTA, 4, 12, 1, 6);
        add_row(PAT_SOLID, GREEN, RED, 11, 11, 5, 3);
    endtask

    task automatic scramble_memory();
        for (int a = 0; a < NPIX; a++)
        begin
            fb_mem[a] = rgb_t'(24'($urandom));
            wr_cnt[a] = 0;
        end
    endtask

    // ------------------------------------------------------------------------
    // write monitor sampling at the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk)
    begin
        int a;
        if (rst_n)
        begin
            if (wr_en)
            begin
                if (wr.addr < ADDR_W'(NPIX))
                begin
                    a         = int'(wr.addr);
                    fb_mem[a] = wr.data;
                    wr_cnt[a] = wr_cnt[a] + 1;
                end
                else
                    note_error("write address lies outside the frame");
                log_addr.push_back(wr.addr);
                log_cycle.push_back(cycle);
                if (!mem_ready)
                    note_error("write strobe while mem_ready is held low");
            end
            if (done)
            begin
                done_cnt   = done_cnt + 1;
                done_cycle = cycle;
            end
        end
        cycle = cycle + 1;
    end

    task automatic run_row(input int idx);
        pattern_cfg_t      c;
        int                n_win;
        int                n_exp;
        int                px;
        int                py;
        int                exp_n;
        bit                in_win;
        rgb_t              exp_pix;
        logic [ADDR_W-1:0] exp_addr;
        c         = tab_cfg[idx];
        cfg       = c;
        divide    = tab_div[idx];
        mem_ready = 1'b0;
        // let the pacer pick up the new divide
        repeat (16) @(negedge clk);
        scramble_memory();
        log_addr.delete();
        log_cycle.delete();
        done_cnt = 0;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_count("busy", 1, int'(busy));
        // memory not ready yet
        repeat (tab_delay[idx])
        begin
            @(negedge clk);
            check_count("busy", 1, int'(busy));
        end
        mem_ready = 1'b1;
        // second start in mid-run is ignored
        while (log_addr.size() < 3)
        begin
            @(negedge clk);
            check_count("busy", 1, int'(busy));
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done_cnt == 0)
        begin
            @(negedge clk);
            if (!done && done_cnt == 0)
                check_count("busy", 1, int'(busy));
        end
        repeat (4) @(negedge clk);
        check_count("done_pulses", 1, done_cnt);
        check_count("busy", 0, int'(busy));
        // done follows the final write by one cycle
        if (log_cycle.size() > 0)
            check_count("done_delay", 1,
                        int'(done_cycle - log_cycle[log_cycle.size()-1]));

        // address order and pacing
        n_win = 0;
        if (window_valid(c))
            n_win = (int'(c.win_bottom) - int'(c.win_top) + 1) * H_DISP;
        n_exp = NPIX + n_win;
        check_count("write_count", n_exp, log_addr.size());
        for (int k = 0; k < log_addr.size() && k < n_exp; k++)
        begin
            if (k < NPIX)
                exp_addr = ADDR_W'(k);
            else
                exp_addr = ADDR_W'(int'(c.win_top) * H_DISP + k - NPIX);
            check_addr("wr.addr", exp_addr, log_addr[k]);
            // phase boundary has no fixed gap
            if (k > 0 && k != NPIX)
                check_count("wr_interval", int'(tab_div[idx]) + 1,
                            int'(log_cycle[k] - log_cycle[k-1]));
        end

        // final frame contents
        for (int a = 0; a < NPIX; a++)
        begin
            px     = a % H_DISP;
            py     = a / H_DISP;
            in_win = window_valid(c) && (py >= int'(c.win_top)) && (py <= int'(c.win_bottom));
            exp_pix = in_win ? c.fg_color : background_pixel(c, px, py);
            exp_n   = in_win ? 2 : 1;
            check_rgb($sformatf("fb_mem[%0d]", a), exp_pix, fb_mem[a]);
            check_count($sformatf("wr_cnt[%0d]", a), exp_n, wr_cnt[a]);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        void'($urandom(SEED));
        palette[0] = RED;
        palette[1] = GREEN;
        palette[2] = BLUE;
        palette[3] = WHITE;
        palette[4] = BLACK;
        palette[5] = YELLOW;
        palette[6] = MAGENTA;
        palette[7] = CYAN;
        rst_n      = 1'b0;
        start      = 1'b0;
        mem_ready  = 1'b0;
        cfg        = '0;
        divide     = 8'd0;
        errors     = 0;
        checks     = 0;
        done_cnt   = 0;
        done_cycle = 0;
        cycle      = 0;
        tab_len    = 0;
        build_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < tab_len; r++)
            run_row(r);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // watchdog with a limit from the table
    initial
    begin
        int limit;
        limit = 40;
        wait (tab_len == N_ROWS);
        for (int r = 0; r < N_ROWS; r++)
            limit = limit + 2 * NPIX * (int'(tab_div[r]) + 1) + tab_delay[r] + 116;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: lcd_pattern.f
rtl/lcd_pattern_pkg.sv
rtl/write_pacer.sv
rtl/fill_sequencer.sv
rtl/fb_addr_gen.sv
rtl/pixel_source.sv
rtl/lcd_pattern_top.sv
testbench/lcd_pattern_assert.sv
testbench/lcd_pattern_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := lcd_pattern_tb
FILELIST  := lcd_pattern.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
